//--- run.sh
#!/bin/bash
set -eo pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f src.f --top-module dma_tb -o dma_sim

./obj_dir/dma_sim +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -q "Test FAILED" sim.log; then
	echo "simulation failed"
	exit 1
fi

echo "simulation passed"
exit 0

//--- src.f
+incdir+verilog
verilog/dma_pkg.sv
verilog/dma_if.sv
verilog/dma_reg.sv
verilog/dma_engine.sv
verilog/dma_bus_arb.sv
verilog/oam_ram.sv
verilog/dma_top.sv
tb/dma_assert.sv
tb/dma_tb.sv

//--- tb/dma_assert.sv
`timescale 1ns/1ps

`include "dma_defs.svh"

module dma_assert (
		input logic        clk,
		input logic        rst,
		input logic [15:0] cpu_addr,
		input logic [7:0]  cpu_wdata,
		input logic        cpu_rd,
		input logic        cpu_wr,
		input logic [7:0]  cpu_rdata,
		input logic [15:0] ext_addr,
		input logic        ext_rd,
		input logic        ext_wr,
		input logic [7:0]  ext_wdata,
		input logic [7:0]  ext_rdata,
		input logic [12:0] vram_addr,
		input logic        vram_rd,
		input logic [7:0]  vram_rdata,
		input logic        dma_run
	);

	int         fails = 0;
	logic       cpu_reg, cpu_oam, cpu_vram, cpu_ext;
	logic       wr_hit;    // cpu write to ff46
	logic       wr_q;      // start slot, one cycle after the write
	logic       seen;      // at least one start since reset
	logic [8:0] age;       // cycles since the last start, saturates
	logic [7:0] last_page; // last value written to ff46
	logic [7:0] run_page;  // page of the running transfer
	logic       run_vram;

	assign cpu_reg  = (cpu_addr == `DMA_REG_ADDR);
	assign cpu_oam  = (cpu_addr >= `OAM_BASE) && (cpu_addr <= `OAM_END);
	assign cpu_vram = (cpu_addr >= `VRAM_BASE) && (cpu_addr <= `VRAM_END);
	assign cpu_ext  = !cpu_reg && !cpu_oam && !cpu_vram;
	assign wr_hit   = cpu_wr && cpu_reg;
	assign run_vram = (run_page >= 8'h80) && (run_page <= 8'h9F);

	// expected run window, taken from the cpu bus alone
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_q      <= 1'b0;
			seen      <= 1'b0;
			age       <= 9'd0;
			last_page <= 8'h00;
			run_page  <= 8'h00;
		end else begin
			wr_q <= wr_hit;
			if (wr_hit) begin
				last_page <= cpu_wdata;
			end
			if (wr_q) begin
				seen     <= 1'b1;
				age      <= 9'd0;
				run_page <= last_page;
			end else if (age < 9'd200) begin
				age <= age + 9'd1;
			end
		end
	end

	run_window: assert property (@(posedge clk) disable iff (rst)
		dma_run == (seen && age < 9'd160))
	else begin
		$error("dma_run is not high for exactly 160 cycles after a start");
		fails++;
	end

	src_addr: assert property (@(posedge clk) disable iff (rst)
		dma_run |-> (run_vram ? (vram_addr == {run_page[4:0], age[7:0]})
			: (ext_addr == {run_page, age[7:0]})))
	else begin
		$error("dma source address is not page*256 plus the byte index");
		fails++;
	end

	src_vram: assert property (@(posedge clk) disable iff (rst)
		dma_run && run_vram |-> vram_rd && (ext_rd == (cpu_rd && cpu_ext)))
	else begin
		$error("vram page transfer drives the wrong read strobes");
		fails++;
	end

	src_ext: assert property (@(posedge clk) disable iff (rst)
		dma_run && !run_vram |-> ext_rd && (vram_rd == (cpu_rd && cpu_vram)))
	else begin
		$error("external page transfer drives the wrong read strobes");
		fails++;
	end

	idle_strobes: assert property (@(posedge clk) disable iff (rst)
		!dma_run |-> (ext_rd == (cpu_rd && cpu_ext)) && (vram_rd == (cpu_rd && cpu_vram)))
	else begin
		$error("read strobes do not follow the cpu while the dma is idle");
		fails++;
	end

	// external writes pass unless the dma is reading that bus
	ext_write: assert property (@(posedge clk) disable iff (rst)
		ext_wr == (cpu_wr && cpu_ext && !(dma_run && !run_vram)))
	else begin
		$error("cpu write to the external bus was not passed or not dropped as required");
		fails++;
	end

	ext_write_data: assert property (@(posedge clk) disable iff (rst)
		ext_wr |-> (ext_wdata == cpu_wdata) && (ext_addr == cpu_addr))
	else begin
		$error("external write does not carry the cpu address and data");
		fails++;
	end

	cpu_blocked: assert property (@(posedge clk) disable iff (rst)
		dma_run && cpu_rd && (cpu_oam || (run_vram ? cpu_vram : cpu_ext))
			|-> cpu_rdata == 8'hFF)
	else begin
		$error("cpu read of oam or of the dma source bus did not return ff");
		fails++;
	end

	cpu_pass: assert property (@(posedge clk) disable iff (rst)
		dma_run && cpu_rd && (run_vram ? cpu_ext : cpu_vram)
			|-> cpu_rdata == (run_vram ? ext_rdata : vram_rdata))
	else begin
		$error("cpu read of the free bus did not pass through during a transfer");
		fails++;
	end

	reg_readback: assert property (@(posedge clk) disable iff (rst)
		cpu_rd && cpu_reg |-> cpu_rdata == last_page)
	else begin
		$error("ff46 read does not return the last value written");
		fails++;
	end

endmodule

bind dma_top dma_assert u_chk (
	.clk        (clk),
	.rst        (rst),
	.cpu_addr   (cpu_addr),
	.cpu_wdata  (cpu_wdata),
	.cpu_rd     (cpu_rd),
	.cpu_wr     (cpu_wr),
	.cpu_rdata  (cpu_rdata),
	.ext_addr   (ext_addr),
	.ext_rd     (ext_rd),
	.ext_wr     (ext_wr),
	.ext_wdata  (ext_wdata),
	.ext_rdata  (ext_rdata),
	.vram_addr  (vram_addr),
	.vram_rd    (vram_rd),
	.vram_rdata (vram_rdata),
	.dma_run    (dma_run)
);

//--- tb/dma_tb.sv
`timescale 1ns/1ps

`include "dma_defs.svh"

module dma_tb;

	logic        clk = 1'b0;
	logic        rst;
	logic [15:0] cpu_addr;
	logic [7:0]  cpu_wdata;
	logic        cpu_rd;
	logic        cpu_wr;
	logic [7:0]  cpu_rdata;
	logic [15:0] ext_addr;
	logic        ext_rd;
	logic        ext_wr;
	logic [7:0]  ext_wdata;
	logic [7:0]  ext_rdata;
	logic [12:0] vram_addr;
	logic        vram_rd;
	logic [7:0]  vram_rdata;
	logic        dma_run;

	logic [31:0] rng;
	logic [7:0]  rd_val;
	int          mismatches;
	int          timeouts;
	int          total;

	dma_top uut (
		.clk        (clk),
		.rst        (rst),
		.cpu_addr   (cpu_addr),
		.cpu_wdata  (cpu_wdata),
		.cpu_rd     (cpu_rd),
		.cpu_wr     (cpu_wr),
		.cpu_rdata  (cpu_rdata),
		.ext_addr   (ext_addr),
		.ext_rd     (ext_rd),
		.ext_wr     (ext_wr),
		.ext_wdata  (ext_wdata),
		.ext_rdata  (ext_rdata),
		.vram_addr  (vram_addr),
		.vram_rd    (vram_rd),
		.vram_rdata (vram_rdata),
		.dma_run    (dma_run)
	);

	// source memories, both answer in the same cycle
	assign ext_rdata  = ext_addr[7:0] ^ ext_addr[15:8];
	assign vram_rdata = vram_addr[7:0] + 8'h5A;

	always #10 clk = ~clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// byte k of a page as the memory models return it
	function automatic logic [7:0] source_byte(input logic [7:0] page, input logic [7:0] k);
		if (page >= 8'h80 && page <= 8'h9F) begin
			return k + 8'h5A;
		end
		return k ^ page;
	endfunction

	task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
		@(posedge clk);
		#2;
		cpu_addr  = addr;
		cpu_wdata = data;
		cpu_rd    = 1'b0;
		cpu_wr    = 1'b1;
		@(posedge clk);
		#2;
		cpu_wr = 1'b0;
	endtask

	task automatic cpu_read(input logic [15:0] addr, output logic [7:0] data);
		@(posedge clk);
		#2;
		cpu_addr = addr;
		cpu_wr   = 1'b0;
		cpu_rd   = 1'b1;
		#10;
		data = cpu_rdata; // mid cycle, settled
	endtask

	task automatic bus_idle();
		@(posedge clk);
		#2;
		cpu_rd = 1'b0;
		cpu_wr = 1'b0;
	endtask

	task automatic wait_run(input logic level, input int limit);
		int n;
		n = 0;
		while (dma_run !== level && n < limit) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (dma_run !== level) begin
			$display("timeout at %0t: dma_run did not go to %0b within %0d cycles",
				$time, level, limit);
			timeouts++;
		end
	endtask

	// oam, vram, external bus and ff46 while a transfer runs
	task automatic probe_reads();
		cpu_read(16'hFE10, rd_val);
		cpu_read(16'h8123, rd_val);
		cpu_read(16'hC234, rd_val);
		cpu_read(`DMA_REG_ADDR, rd_val);
		cpu_write(16'hC234, 8'hA5); // dropped only on an external page
		bus_idle();
	endtask

	task automatic check_oam(input logic [7:0] page);
		logic [7:0] got;
		logic [7:0] exp;
		for (int k = 0; k < `DMA_LEN; k++) begin
			cpu_read(`OAM_BASE + 16'(k), got);
			exp = source_byte(page, 8'(k));
			if (got !== exp) begin
				$display("mismatch at %0t: cpu_rdata oam[%0d] got %02h expected %02h",
					$time, k, got, exp);
				mismatches++;
			end
		end
		bus_idle();
	endtask

	task automatic run_transfer(input logic [7:0] page);
		cpu_write(`DMA_REG_ADDR, page);
		wait_run(1'b1, 4);
		probe_reads();
		wait_run(1'b0, 200);
		cpu_read(`DMA_REG_ADDR, rd_val);
		check_oam(page);
	endtask

	// second write lands mid-run and restarts the copy
	task automatic restart_transfer(input logic [7:0] first, input logic [7:0] second,
		input int delay);
		cpu_write(`DMA_REG_ADDR, first);
		wait_run(1'b1, 4);
		repeat (delay) @(posedge clk);
		cpu_write(`DMA_REG_ADDR, second);
		probe_reads();
		wait_run(1'b0, 200);
		check_oam(second);
	endtask

	initial begin
		rst        = 1'b1;
		cpu_addr   = 16'h0000;
		cpu_wdata  = 8'h00;
		cpu_rd     = 1'b0;
		cpu_wr     = 1'b0;
		rng        = 32'ha9ec6860;
		mismatches = 0;
		timeouts   = 0;
		repeat (2) @(posedge clk);
		#2;
		rst = 1'b0;

		cpu_read(`DMA_REG_ADDR, rd_val); // reset value
		cpu_write(16'hC234, 8'h5A); // idle write reaches the external bus
		bus_idle();

		run_transfer(8'h80);
		run_transfer(8'hC1);
		run_transfer(8'h9F);
		rng = xorshift32(rng);
		run_transfer(rng[7:0]);

		restart_transfer(8'h85, 8'h3C, 40); // vram page replaced by an external one
		for (int i = 0; i < 3; i++) begin
			rng = xorshift32(rng);
			restart_transfer(rng[7:0], rng[15:8], 5 + (int'(rng[23:16]) % 140));
		end

		repeat (4) @(posedge clk);
		total = mismatches + timeouts + uut.u_chk.fails;
		$display("errors: %0d mismatches, %0d assertion failures, %0d timeouts",
			mismatches, uut.u_chk.fails, timeouts);
		if (total == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

//--- verilog/dma_bus_arb.sv
`timescale 1ns/1ps
`default_nettype none

`include "dma_defs.svh"

module dma_bus_arb (
		input  logic [15:0] cpu_addr,
		input  logic [7:0]  cpu_wdata,
		input  logic        cpu_rd,
		input  logic        cpu_wr,
		output logic [7:0]  cpu_rdata,
		output logic        reg_wr,
		input  logic [7:0]  page,
		dma_src_if.arb      src,
		output logic [15:0] ext_addr,
		output logic        ext_rd,
		output logic        ext_wr,
		output logic [7:0]  ext_wdata,
		input  logic [7:0]  ext_rdata,
		output logic [12:0] vram_addr,
		output logic        vram_rd,
		input  logic [7:0]  vram_rdata,
		output logic        oam_cpu_sel,
		input  logic [7:0]  oam_rdata
	);

	import dma_pkg::*;

	logic hit_reg, hit_oam, hit_vram, hit_ext;
	logic dma_ext, dma_vram; // bus owned by the dma

	// cpu address decode
	assign hit_reg  = (cpu_addr == `DMA_REG_ADDR);
	assign hit_oam  = (cpu_addr >= `OAM_BASE) && (cpu_addr <= `OAM_END);
	assign hit_vram = (cpu_addr >= `VRAM_BASE) && (cpu_addr <= `VRAM_END);
	assign hit_ext  = !hit_reg && !hit_oam && !hit_vram;

	assign dma_ext  = src.active && (src.region == SRC_EXT);
	assign dma_vram = src.active && (src.region == SRC_VRAM);

	assign reg_wr      = cpu_wr && hit_reg; // ff46 stays writable mid-run
	assign oam_cpu_sel = hit_oam;           // oam locks itself while busy

	// external bus, cpu writes dropped while the dma reads it
	assign ext_addr  = dma_ext ? src.addr.raw : cpu_addr;
	assign ext_rd    = dma_ext || (cpu_rd && hit_ext);
	assign ext_wr    = !dma_ext && cpu_wr && hit_ext;
	assign ext_wdata = cpu_wdata;

	assign vram_addr = dma_vram ? src.addr.raw[12:0] : cpu_addr[12:0];
	assign vram_rd   = dma_vram || (cpu_rd && hit_vram);

	assign src.rdata = (src.region == SRC_VRAM) ? vram_rdata : ext_rdata;

	// cpu read mux, a blocked bus answers ff
	always_comb begin
		if (!cpu_rd) begin
			cpu_rdata = 8'hFF;
		end else if (hit_reg) begin
			cpu_rdata = page;
		end else if (hit_oam) begin
			cpu_rdata = oam_rdata;
		end else if (hit_vram) begin
			cpu_rdata = dma_vram ? 8'hFF : vram_rdata;
		end else begin
			cpu_rdata = dma_ext ? 8'hFF : ext_rdata;
		end
	end

endmodule

//--- verilog/dma_defs.svh
`ifndef DMA_DEFS_SVH
`define DMA_DEFS_SVH

// transfer length and last byte index
`define DMA_LEN      160
`define DMA_LAST     8'h9F

// cpu address of the dma source page register
`define DMA_REG_ADDR 16'hFF46

// cpu window of object attribute memory
`define OAM_BASE     16'hFE00
`define OAM_END      16'hFE9F

// cpu window of video ram
`define VRAM_BASE    16'h8000
`define VRAM_END     16'h9FFF

`endif

//--- verilog/dma_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "dma_defs.svh"

module dma_engine (
		input  logic       clk,
		input  logic       rst,
		input  logic       start,
		input  logic [7:0] page,
		dma_src_if.engine  src,
		dma_oam_if.engine  oam,
		output logic       dma_run
	);

	import dma_pkg::*;

	logic        run_q;    // transfer in progress
	dma_addr_u   addr_q;   // latched page and running offset
	logic        last;     // final byte this cycle
	dma_region_e region;

	assign last = (addr_q.pg.offset == `DMA_LAST);

	// run flag
	// a start while running keeps the flag set and restarts the count
	always_ff @(posedge clk) begin
		if (rst) begin
			run_q <= 1'b0;
		end else if (start) begin
			run_q <= 1'b1;
		end else if (run_q && last) begin
			run_q <= 1'b0;
		end
	end

	// source address, page from ff46 and offset as the byte counter
	always_ff @(posedge clk) begin
		if (rst) begin
			addr_q.raw <= 16'h0000;
		end else if (start) begin
			addr_q.pg.page   <= page;
			addr_q.pg.offset <= 8'h00;
		end else if (run_q && !last) begin
			addr_q.pg.offset <= addr_q.pg.offset + 8'h01;
		end
	end

	// pages 80 to 9f sit on the vram bus
	always_comb begin
		if (addr_q.pg.page[7:5] == 3'b100) begin
			region = SRC_VRAM;
		end else begin
			region = SRC_EXT;
		end
	end

	// source bus request
	always_comb begin
		src.addr   = addr_q;
		src.region = region;
		src.active = run_q;
	end

	// byte k of the page goes to oam index k in the same cycle
	always_comb begin
		oam.idx   = addr_q.pg.offset;
		oam.wdata = src.rdata;
		oam.we    = run_q;
		oam.busy  = run_q;
	end

	assign dma_run = run_q;

endmodule

//--- verilog/dma_if.sv
`timescale 1ns/1ps
`default_nettype none

// source side of the dma, engine to bus arbiter
interface dma_src_if;
	import dma_pkg::*;

	dma_addr_u   addr;   // valid only while active
	dma_region_e region; // bus select
	logic        active; // dma owns the selected bus
	logic [7:0]  rdata;  // same-cycle read data

	modport engine (
		output addr, region, active,
		input  rdata
	);

	modport arb (
		input  addr, region, active,
		output rdata
	);

endinterface

// write side of the dma, engine to oam
interface dma_oam_if;
	logic [7:0] idx;   // oam byte index
	logic [7:0] wdata; // byte to store
	logic       we;    // store at the rising edge
	logic       busy;  // oam locked against the cpu

	modport engine (
		output idx, wdata, we, busy
	);

	modport oam (
		input idx, wdata, we, busy
	);

endinterface

//--- verilog/dma_pkg.sv
package dma_pkg;

	// page and offset view of a dma source address
	typedef struct packed {
		logic [7:0] page;   // high byte, loaded from ff46
		logic [7:0] offset; // low byte, counts 0 to 9f
	} dma_pg_t;

	// one 16-bit source word seen two ways
	typedef union packed {
		logic [15:0] raw; // full address on the bus
		dma_pg_t     pg;  // split for the engine
	} dma_addr_u;

	// which bus the dma reads from
	typedef enum logic [1:0] {
		SRC_EXT  = 2'd0, // external bus
		SRC_VRAM = 2'd1  // video ram bus, pages 80 to 9f
	} dma_region_e;

endpackage

//--- verilog/dma_reg.sv
`timescale 1ns/1ps
`default_nettype none

module dma_reg (
		input  logic       clk,
		input  logic       rst,
		input  logic       reg_wr,
		input  logic [7:0] wdata,
		output logic [7:0] page,
		output logic       start
	);

	logic [7:0] page_q;
	logic       start_q;

	// ff46 latch, reads back the last value written
	always_ff @(posedge clk) begin
		if (rst) begin
			page_q <= 8'h00;
		end else if (reg_wr) begin
			page_q <= wdata;
		end
	end

	// write strobe delayed by one clock
	// the engine sees start together with the new page
	always_ff @(posedge clk) begin
		if (rst) begin
			start_q <= 1'b0;
		end else begin
			start_q <= reg_wr;
		end
	end

	assign page  = page_q;
	assign start = start_q; // one-cycle pulse

endmodule

//--- verilog/dma_top.sv
`timescale 1ns/1ps
`default_nettype none

module dma_top (
		input  logic        clk,
		input  logic        rst,

		input  logic [15:0] cpu_addr,
		input  logic [7:0]  cpu_wdata,
		input  logic        cpu_rd,
		input  logic        cpu_wr,
		output logic [7:0]  cpu_rdata,

		output logic [15:0] ext_addr,
		output logic        ext_rd,
		output logic        ext_wr,
		output logic [7:0]  ext_wdata,
		input  logic [7:0]  ext_rdata,

		output logic [12:0] vram_addr,
		output logic        vram_rd,
		input  logic [7:0]  vram_rdata,

		output logic        dma_run
	);

	logic       reg_wr;
	logic [7:0] page;
	logic       start;
	logic       oam_cpu_sel;
	logic [7:0] oam_rdata;

	dma_src_if src_bus ();
	dma_oam_if oam_bus ();

	dma_reg u_reg (
		.clk    (clk),
		.rst    (rst),
		.reg_wr (reg_wr),
		.wdata  (cpu_wdata),
		.page   (page),
		.start  (start)
	);

	dma_engine u_engine (
		.clk     (clk),
		.rst     (rst),
		.start   (start),
		.page    (page),
		.src     (src_bus.engine),
		.oam     (oam_bus.engine),
		.dma_run (dma_run)
	);

	dma_bus_arb u_arb (
		.cpu_addr    (cpu_addr),
		.cpu_wdata   (cpu_wdata),
		.cpu_rd      (cpu_rd),
		.cpu_wr      (cpu_wr),
		.cpu_rdata   (cpu_rdata),
		.reg_wr      (reg_wr),
		.page        (page),
		.src         (src_bus.arb),
		.ext_addr    (ext_addr),
		.ext_rd      (ext_rd),
		.ext_wr      (ext_wr),
		.ext_wdata   (ext_wdata),
		.ext_rdata   (ext_rdata),
		.vram_addr   (vram_addr),
		.vram_rd     (vram_rd),
		.vram_rdata  (vram_rdata),
		.oam_cpu_sel (oam_cpu_sel),
		.oam_rdata   (oam_rdata)
	);

	oam_ram u_oam (
		.clk       (clk),
		.dma       (oam_bus.oam),
		.cpu_sel   (oam_cpu_sel),
		.cpu_wr    (cpu_wr),
		.cpu_idx   (cpu_addr[7:0]), // fe00 window, low byte is the index
		.cpu_wdata (cpu_wdata),
		.rdata     (oam_rdata)
	);

endmodule

//--- verilog/oam_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "dma_defs.svh"

module oam_ram (
		input  logic       clk,
		dma_oam_if.oam     dma,
		input  logic       cpu_sel,
		input  logic       cpu_wr,
		input  logic [7:0] cpu_idx,
		input  logic [7:0] cpu_wdata,
		output logic [7:0] rdata
	);

	logic [7:0] mem [0:`DMA_LEN-1];
	logic       cpu_we;
	logic       cpu_in_range;

	assign cpu_in_range = (cpu_idx < 8'(`DMA_LEN));
	assign cpu_we       = cpu_sel && cpu_wr && cpu_in_range && !dma.busy;

	// dma port has priority, cpu only gets in while idle
	always_ff @(posedge clk) begin
		if (dma.we) begin
			mem[dma.idx] <= dma.wdata;
		end else if (cpu_we) begin
			mem[cpu_idx] <= cpu_wdata;
		end
	end

	// async cpu read
	always_comb begin
		if (dma.busy || !cpu_in_range) begin
			rdata = 8'hFF;
		end else begin
			rdata = mem[cpu_idx];
		end
	end

endmodule
